//--- common/task_map_config.svh
/*
 * Task mapper configuration
 * Mesh, cluster and scan sizes shared by the RTL
 */

`ifndef TASK_MAP_CONFIG_SVH
`define TASK_MAP_CONFIG_SVH

// Side of one cluster in PEs
`define TM_GRID 4

// Clusters in the mesh, cluster 0 belongs to the main controller
`define TM_CLUSTERS 4

// Side of the whole mesh in PEs
`define TM_MESH 8

// Largest Manhattan distance that still counts as a neighbour
`define TM_NBR_DIST 2

// PE positions scanned per cluster
`define TM_SCAN_LEN 16

`endif

//--- common/task_map_pkg.sv
/*
 * Task mapper package
 * Width types for PE positions, ids and counts, and the controller states
 */

`default_nettype none

`include "task_map_config.svh"

package task_map_pkg;

  // Row or column inside one cluster
  typedef logic [$clog2(`TM_GRID)-1:0] coord_t;

  // Scan position, row * TM_GRID + column
  typedef logic [$clog2(`TM_SCAN_LEN)-1:0] pe_idx_t;

  typedef logic [$clog2(`TM_CLUSTERS)-1:0] cluster_t;

  // Global PE id over the full mesh
  typedef logic [$clog2(`TM_MESH*`TM_MESH)-1:0] pe_id_t;

  // Busy PEs of a cluster, 0 to TM_SCAN_LEN
  typedef logic [$clog2(`TM_SCAN_LEN+1)-1:0] occ_count_t;

  // At most 12 idle PEs lie within distance 2 in a 4x4 cluster
  typedef logic [3:0] nbr_count_t;

  // One bit per scan position, set means busy
  typedef logic [`TM_SCAN_LEN-1:0] occ_bits_t;

  typedef enum logic [1:0] {
    st_idle,
    st_scan,
    st_resp,
    st_select
  } map_state_t;

endpackage

`default_nettype wire

//--- common/map_ifs.sv
/*
 * Internal buses of the task mapper
 * scan_if carries the scan sequence, occ_if the occupancy view
 */

`timescale 1ns/10ps
`default_nettype none

`include "task_map_config.svh"

// ####################
// Scan sequencing
// ####################
interface scan_if import task_map_pkg::*; ();
  logic    start;
  logic    root;
  pe_idx_t pos;
  logic    step;
  logic    last;

  modport master  (output start, output root, input last);
  modport counter (input start, output pos, output step, output last);
  modport scorer  (input start, input root, input pos, input step, input last);
endinterface

// ####################
// Occupancy view
// ####################
interface occ_if import task_map_pkg::*; ();
  occ_bits_t  active_bits;
  occ_count_t counts [`TM_CLUSTERS];
  cluster_t   active;
  logic       alloc;
  pe_idx_t    alloc_pos;

  modport provider (
    output active_bits, output counts,
    input  active, input alloc, input alloc_pos
  );
  modport scorer   (input active_bits, input active, output alloc, output alloc_pos);
  modport selector (input counts, output active);
endinterface

`default_nettype wire

//--- hw/map_ctrl_fsm.sv
/*
 * Mapper control FSM
 * Accepts one task at a time, runs the scan, holds the response
 * and triggers cluster selection at the end of an application
 */

`timescale 1ns/10ps
`default_nettype none

module map_ctrl_fsm import task_map_pkg::*; (
  input  logic   clk,
  input  logic   rst_b,
  input  logic   task_valid,
  input  logic   task_root,
  output logic   task_ready,
  input  logic   app_end,
  input  logic   map_ready,
  output logic   map_valid,
  output logic   select,
  scan_if.master scan
);

  map_state_t state;
  map_state_t state_nxt;
  logic       start_q;
  logic       root_q;
  logic       last_q;

  always_comb begin
    state_nxt = state;
    unique case (state)
      st_idle: begin
        // A waiting task has priority over app_end
        if (task_valid) begin
          state_nxt = st_scan;
        end else if (app_end) begin
          state_nxt = st_select;
        end
      end
      // One extra cycle after last lets the scorer load its result
      st_scan:   if (last_q) state_nxt = st_resp;
      st_resp:   if (map_ready) state_nxt = st_idle;
      st_select: state_nxt = st_idle;
      default:   state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      state   <= st_idle;
      start_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      state   <= state_nxt;
      start_q <= (state == st_idle) && task_valid;
      last_q  <= scan.last;
    end
  end

  // Root flag of the accepted task, held until the next accept
  always_ff @(posedge clk) begin
    if ((state == st_idle) && task_valid) begin
      root_q <= task_root;
    end
  end

  assign task_ready = (state == st_idle);
  assign map_valid  = (state == st_resp);
  assign select     = (state == st_select);
  assign scan.start = start_q;
  assign scan.root  = root_q;

endmodule

`default_nettype wire

//--- hw/pe_scan_counter.sv
/*
 * PE scan counter
 * Presents every position of the active cluster once per scan
 */

`timescale 1ns/10ps
`default_nettype none

`include "task_map_config.svh"

module pe_scan_counter import task_map_pkg::*; (
  input  logic    clk,
  input  logic    rst_b,
  scan_if.counter scan
);

  pe_idx_t pos_q;
  logic    step_q;

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      pos_q  <= '0;
      step_q <= 1'b0;
    end else if (scan.start) begin
      pos_q  <= '0;
      step_q <= 1'b1;
    end else if (step_q) begin
      if (scan.last) begin
        step_q <= 1'b0;
      end else begin
        pos_q <= pos_q + 1'b1;
      end
    end
  end

  assign scan.pos  = pos_q;
  assign scan.step = step_q;
  assign scan.last = step_q && (pos_q == pe_idx_t'(`TM_SCAN_LEN - 1));

endmodule

`default_nettype wire

//--- hw/pe_scorer.sv
/*
 * PE scorer
 * Rates each scanned PE by its idle neighbours and its distance to the
 * controller corner, keeps the best idle PE and forms the id pair
 */

`timescale 1ns/10ps
`default_nettype none

`include "task_map_config.svh"

module pe_scorer import task_map_pkg::*; (
  input  logic   clk,
  input  logic   rst_b,
  scan_if.scorer scan,
  occ_if.scorer  occ,
  output pe_id_t src_id,
  output pe_id_t dest_id,
  output logic   map_full
);

  // Idle PEs at distance 1 to TM_NBR_DIST from position p
  function automatic nbr_count_t idle_nbrs(input occ_bits_t bits, input pe_idx_t p);
    nbr_count_t n;
    int         dr;
    int         dc;
    n = '0;
    for (int q = 0; q < `TM_SCAN_LEN; q++) begin
      dr = q / `TM_GRID - int'(p) / `TM_GRID;
      dc = q % `TM_GRID - int'(p) % `TM_GRID;
      if (dr < 0) dr = -dr;
      if (dc < 0) dc = -dc;
      if (!bits[q] && (dr + dc >= 1) && (dr + dc <= `TM_NBR_DIST)) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  // Local position to mesh id, using the row and column offset of the cluster
  function automatic pe_id_t global_id(input cluster_t c, input pe_idx_t p);
    int grow;
    int gcol;
    grow = int'(p) / `TM_GRID + (c[1] ? `TM_GRID : 0);
    gcol = int'(p) % `TM_GRID + ((c[1] ^ c[0]) ? `TM_GRID : 0);
    return pe_id_t'(grow * `TM_MESH + gcol);
  endfunction

  coord_t     cur_row;
  coord_t     cur_col;
  logic [2:0] cur_dist;
  nbr_count_t cur_nbr;
  logic       better;
  logic       best_valid;
  pe_idx_t    best_pos;
  nbr_count_t best_nbr;
  logic [2:0] best_dist;
  logic       done_q;
  pe_id_t     new_id;

  // ####################
  // Score of the current position
  // ####################
  assign cur_row = coord_t'(scan.pos / `TM_GRID);
  assign cur_col = coord_t'(scan.pos % `TM_GRID);
  // Corner row is the far row for clusters 2 and 3, far column for 1 and 2
  assign cur_dist = {1'b0, cur_row ^ {$bits(coord_t){occ.active[1]}}}
                  + {1'b0, cur_col ^ {$bits(coord_t){occ.active[1] ^ occ.active[0]}}};
  assign cur_nbr  = idle_nbrs(occ.active_bits, scan.pos);

  // Strict compare keeps the earlier position on a full tie
  assign better = !occ.active_bits[scan.pos]
               && (!best_valid || (cur_nbr > best_nbr)
                   || ((cur_nbr == best_nbr) && (cur_dist < best_dist)));

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      best_valid <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= scan.step && scan.last;
      if (scan.start) begin
        best_valid <= 1'b0;
      end else if (scan.step && better) begin
        best_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (scan.step && better) begin
      best_pos  <= scan.pos;
      best_nbr  <= cur_nbr;
      best_dist <= cur_dist;
    end
  end

  // ####################
  // Result register
  // ####################
  assign new_id = global_id(occ.active, best_pos);

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      src_id   <= '0;
      dest_id  <= '0;
      map_full <= 1'b0;
    end else if (done_q) begin
      map_full <= !best_valid;
      if (best_valid) begin
        dest_id <= new_id;
        src_id  <= scan.root ? new_id : dest_id;
      end else begin
        // Cluster full, the task stays on the previous PE
        src_id <= dest_id;
      end
    end
  end

  assign occ.alloc     = done_q && best_valid;
  assign occ.alloc_pos = best_pos;

endmodule

`default_nettype wire

//--- hw/occupancy/occupancy_map.sv
/*
 * Cluster occupancy map
 * One busy bit per PE for every cluster, with a busy count per cluster
 */

`timescale 1ns/10ps
`default_nettype none

`include "task_map_config.svh"

module occupancy_map import task_map_pkg::*; (
  input  logic    clk,
  input  logic    rst_b,
  occ_if.provider occ
);

  occ_bits_t  occ_bits [`TM_CLUSTERS];
  occ_count_t pop      [`TM_CLUSTERS];

  // PEs are only freed by reset
  always_ff @(posedge clk) begin
    if (!rst_b) begin
      for (int c = 0; c < `TM_CLUSTERS; c++) begin
        occ_bits[c] <= '0;
      end
    end else if (occ.alloc) begin
      occ_bits[occ.active][occ.alloc_pos] <= 1'b1;
    end
  end

  // ####################
  // Busy counts
  // ####################
  always_comb begin
    for (int c = 0; c < `TM_CLUSTERS; c++) begin
      pop[c] = '0;
      for (int p = 0; p < `TM_SCAN_LEN; p++) begin
        pop[c] = pop[c] + occ_count_t'(occ_bits[c][p]);
      end
    end
  end

  always_comb begin
    for (int c = 0; c < `TM_CLUSTERS; c++) begin
      occ.counts[c] = pop[c];
    end
  end

  // Matrix of the cluster being scanned
  assign occ.active_bits = occ_bits[occ.active];

endmodule

`default_nettype wire

//--- hw/occupancy/cluster_selector.sv
/*
 * Cluster selector
 * Holds the active cluster and moves to the least occupied one on select
 */

`timescale 1ns/10ps
`default_nettype none

`include "task_map_config.svh"

module cluster_selector import task_map_pkg::*; (
  input  logic    clk,
  input  logic    rst_b,
  input  logic    select,
  occ_if.selector occ
);

  cluster_t   min_idx;
  occ_count_t min_cnt;
  cluster_t   active_q;

  // Less-or-equal lets a later cluster win a tie
  always_comb begin
    min_idx = '0;
    min_cnt = '1;
    for (int c = 0; c < `TM_CLUSTERS; c++) begin
      if (occ.counts[c] <= min_cnt) begin
        min_cnt = occ.counts[c];
        min_idx = cluster_t'(c);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      active_q <= '0;
    end else if (select) begin
      active_q <= min_idx;
    end
  end

  assign occ.active = active_q;

endmodule

`default_nettype wire

//--- hw/task_mapper.sv
/*
 * Task mapper top level
 * Maps tasks onto a mesh of four 4x4 PE clusters over valid/ready ports
 */

`timescale 1ns/10ps
`default_nettype none

module task_mapper import task_map_pkg::*; (
  input  logic     clk,
  input  logic     rst_b,
  input  logic     task_valid,
  output logic     task_ready,
  input  logic     task_root,
  input  logic     app_end,
  output logic     map_valid,
  input  logic     map_ready,
  output pe_id_t   src_id,
  output pe_id_t   dest_id,
  output logic     map_full,
  output cluster_t active_cluster
);

  logic select;

  scan_if scan_bus ();
  occ_if  occ_bus ();

  map_ctrl_fsm u_ctrl (
    .clk        (clk),
    .rst_b      (rst_b),
    .task_valid (task_valid),
    .task_root  (task_root),
    .task_ready (task_ready),
    .app_end    (app_end),
    .map_ready  (map_ready),
    .map_valid  (map_valid),
    .select     (select),
    .scan       (scan_bus.master)
  );

  pe_scan_counter u_counter (
    .clk   (clk),
    .rst_b (rst_b),
    .scan  (scan_bus.counter)
  );

  pe_scorer u_scorer (
    .clk      (clk),
    .rst_b    (rst_b),
    .scan     (scan_bus.scorer),
    .occ      (occ_bus.scorer),
    .src_id   (src_id),
    .dest_id  (dest_id),
    .map_full (map_full)
  );

  occupancy_map u_occ (
    .clk   (clk),
    .rst_b (rst_b),
    .occ   (occ_bus.provider)
  );

  cluster_selector u_select (
    .clk    (clk),
    .rst_b  (rst_b),
    .select (select),
    .occ    (occ_bus.selector)
  );

  assign active_cluster = occ_bus.active;

endmodule

`default_nettype wire

//--- bench/task_mapper_sva.sv
/*
 * Task mapper assertions
 * Reset state and response handshake checks, bound into the top level
 */

`timescale 1ns/10ps
`default_nettype none

module task_mapper_sva import task_map_pkg::*; (
  input logic     clk,
  input logic     rst_b,
  input logic     task_valid,
  input logic     task_ready,
  input logic     map_valid,
  input logic     map_ready,
  input pe_id_t   src_id,
  input pe_id_t   dest_id,
  input logic     map_full,
  input cluster_t active_cluster
);

  // Reset leaves the mapper idle on cluster 0
  reset_state_a: assert property (@(posedge clk)
    !rst_b |=> task_ready && !map_valid && (active_cluster == '0))
    else $error("mapper not idle on cluster 0 after reset");

  // Response data holds while the consumer stalls
  resp_hold_a: assert property (@(posedge clk) disable iff (!rst_b)
    map_valid && !map_ready |=>
      map_valid && $stable(src_id) && $stable(dest_id) && $stable(map_full))
    else $error("response changed while map_ready was low");

  // A response only rises 18 cycles after the edge that took its task
  resp_latency_a: assert property (@(posedge clk) disable iff (!rst_b)
    $rose(map_valid) |-> $past(task_valid && task_ready, 19))
    else $error("map_valid rose without a task accepted 18 cycles before");

endmodule

bind task_mapper task_mapper_sva u_sva (
  .clk            (clk),
  .rst_b          (rst_b),
  .task_valid     (task_valid),
  .task_ready     (task_ready),
  .map_valid      (map_valid),
  .map_ready      (map_ready),
  .src_id         (src_id),
  .dest_id        (dest_id),
  .map_full       (map_full),
  .active_cluster (active_cluster)
);

`default_nettype wire

//--- bench/task_mapper_tb.sv
/*
 * Task mapper testbench
 * Directed tests checked against a reference model of the mapping rules
 */

`timescale 1ns/10ps
`default_nettype none

`include "task_map_config.svh"

module task_mapper_tb import task_map_pkg::*; ();

  logic        clk = 1'b0;
  logic        rst_b;
  logic        task_valid;
  logic        task_ready;
  logic        task_root;
  logic        app_end;
  logic        map_valid;
  logic        map_ready;
  pe_id_t      src_id;
  pe_id_t      dest_id;
  logic        map_full;
  cluster_t    active_cluster;
  occ_bits_t   model_occ [`TM_CLUSTERS];
  cluster_t    model_active;
  pe_id_t      model_dest;
  pe_id_t      last_dest;
  logic [63:0] used_ids;
  int          errors;
  int          checks;

  always #2 clk = ~clk;

  task_mapper dut (.*);

  // ####################
  // Reference model
  // ####################
  function automatic int abs_diff(input int a, input int b);
    return (a > b) ? a - b : b - a;
  endfunction

  function automatic int idle_near(input cluster_t c, input int p);
    int n;
    int d;
    n = 0;
    for (int q = 0; q < `TM_SCAN_LEN; q++) begin
      d = abs_diff(q / 4, p / 4) + abs_diff(q % 4, p % 4);
      if (!model_occ[c][q] && d >= 1 && d <= `TM_NBR_DIST) n++;
    end
    return n;
  endfunction

  // Corners sit at (0,0), (0,3), (3,3) and (3,0)
  function automatic int corner_dist(input cluster_t c, input int p);
    int cr;
    int cc;
    cr = (c == 2 || c == 3) ? 3 : 0;
    cc = (c == 1 || c == 2) ? 3 : 0;
    return abs_diff(p / 4, cr) + abs_diff(p % 4, cc);
  endfunction

  function automatic pe_id_t mesh_id(input cluster_t c, input int p);
    int ro;
    int co;
    ro = (c >= 2) ? 4 : 0;
    co = (c == 1 || c == 2) ? 4 : 0;
    return pe_id_t'((p / 4 + ro) * `TM_MESH + p % 4 + co);
  endfunction

  // Scan from the top index down so a tie keeps the highest cluster
  function automatic cluster_t least_busy();
    cluster_t pick;
    int       best;
    int       cnt;
    pick = '0;
    best = 99;
    for (int c = `TM_CLUSTERS - 1; c >= 0; c--) begin
      cnt = $countones(model_occ[c]);
      if (cnt < best) begin
        best = cnt;
        pick = cluster_t'(c);
      end
    end
    return pick;
  endfunction

  task automatic predict(input logic root, output pe_id_t e_src, output pe_id_t e_dest,
                         output logic e_full);
    int best;
    int best_nbr;
    int best_dist;
    int n;
    int d;
    best = -1;
    best_nbr = 0;
    best_dist = 0;
    for (int p = 0; p < `TM_SCAN_LEN; p++) begin
      if (!model_occ[model_active][p]) begin
        n = idle_near(model_active, p);
        d = corner_dist(model_active, p);
        if (best < 0 || n > best_nbr || (n == best_nbr && d < best_dist)) begin
          best = p;
          best_nbr = n;
          best_dist = d;
        end
      end
    end
    e_full = (best < 0);
    e_src  = model_dest;
    e_dest = model_dest;
    if (best >= 0) begin
      e_dest = mesh_id(model_active, best);
      e_src  = root ? e_dest : model_dest;
      model_occ[model_active][best] = 1'b1;
      model_dest = e_dest;
    end
  endtask

  // ####################
  // Helpers
  // ####################
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("Timeout at %0t: %s", $time, what);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!task_ready && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (!task_ready) abort_run("task_ready did not return high");
  endtask

  // Sends one task, checks the response, then takes it after a random stall
  task automatic run_task(input logic root, input int max_stall, input logic check_lat);
    pe_id_t e_src;
    pe_id_t e_dest;
    logic   e_full;
    pe_id_t held_src;
    pe_id_t held_dest;
    int     lat;
    int     stall;
    wait_ready();
    predict(root, e_src, e_dest, e_full);
    task_valid = 1'b1;
    task_root  = root;
    @(negedge clk);
    task_valid = 1'b0;
    task_root  = 1'b0;
    lat = 0;
    while (!map_valid && lat < 40) begin
      @(negedge clk);
      lat++;
    end
    if (!map_valid) abort_run("no response after an accepted task");
    if (check_lat) check_val("map_valid latency", lat, 18);
    check_val("src_id", src_id, e_src);
    check_val("dest_id", dest_id, e_dest);
    check_val("map_full", map_full, e_full);
    if (!root && !map_full) check_val("src_id vs previous dest_id", src_id, last_dest);
    if (map_full) begin
      check_val("dest_id on full cluster", dest_id, src_id);
    end else begin
      if (used_ids[dest_id]) begin
        errors++;
        $display("PE id %0d was mapped twice (t=%0t)", dest_id, $time);
      end
      used_ids[dest_id] = 1'b1;
    end
    held_src  = src_id;
    held_dest = dest_id;
    stall = (max_stall > 0) ? int'($urandom % (max_stall + 1)) : 0;
    repeat (stall) begin
      @(negedge clk);
      check_val("map_valid under stall", map_valid, 1);
      check_val("src_id under stall", src_id, held_src);
      check_val("dest_id under stall", dest_id, held_dest);
    end
    map_ready = 1'b1;
    @(negedge clk);
    map_ready = 1'b0;
    check_val("map_valid after handshake", map_valid, 0);
    last_dest = held_dest;
  endtask

  task automatic end_application(input cluster_t exp_c);
    wait_ready();
    app_end = 1'b1;
    @(negedge clk);
    app_end = 1'b0;
    check_val("task_ready during select", task_ready, 0);
    @(negedge clk);
    model_active = least_busy();
    check_val("active_cluster", active_cluster, model_active);
    check_val("active_cluster", active_cluster, exp_c);
    check_val("task_ready after select", task_ready, 1);
  endtask

  // ####################
  // Directed tests
  // ####################
  task automatic test_reset_state();
    check_val("task_ready", task_ready, 1);
    check_val("map_valid", map_valid, 0);
    check_val("active_cluster", active_cluster, 0);
  endtask

  task automatic test_root_task();
    run_task(1'b1, 0, 1'b1);
  endtask

  task automatic test_child_chain();
    repeat (2) run_task(1'b0, 0, 1'b1);
  endtask

  task automatic test_app_end_select();
    end_application(cluster_t'(3));
    run_task(1'b1, 0, 1'b1);
    if (dest_id / 8 < 4 || dest_id % 8 >= 4) begin
      errors++;
      $display("dest_id %0d lies outside cluster 3 (t=%0t)", dest_id, $time);
    end
  endtask

  task automatic test_ready_stalls();
    repeat (4) run_task(1'b0, 6, 1'b0);
  endtask

  // Cluster 2 ties with cluster 1 at zero and wins on index
  task automatic test_full_cluster();
    end_application(cluster_t'(2));
    run_task(1'b1, 0, 1'b0);
    repeat (15) run_task(1'b0, 2, 1'b0);
    run_task(1'b0, 0, 1'b1);
    check_val("map_full on 17th task", map_full, 1);
    check_val("dest_id on 17th task", dest_id, src_id);
  endtask

  initial begin
    void'($urandom(18));
    errors = 0;
    checks = 0;
    used_ids = '0;
    model_active = '0;
    model_dest = '0;
    last_dest = '0;
    for (int c = 0; c < `TM_CLUSTERS; c++) begin
      model_occ[c] = '0;
    end
    rst_b = 1'b0;
    task_valid = 1'b0;
    task_root = 1'b0;
    app_end = 1'b0;
    map_ready = 1'b0;
    repeat (4) @(negedge clk);
    rst_b = 1'b1;
    @(negedge clk);
    test_reset_state();
    test_root_task();
    test_child_chain();
    test_app_end_select();
    test_ready_stalls();
    test_full_cluster();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/task_map_pkg.sv
common/map_ifs.sv
hw/map_ctrl_fsm.sv
hw/pe_scan_counter.sv
hw/pe_scorer.sv
hw/occupancy/occupancy_map.sv
hw/occupancy/cluster_selector.sv
hw/task_mapper.sv
bench/task_mapper_sva.sv
bench/task_mapper_tb.sv

//--- Makefile
TOP := task_mapper_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
